// ==== rtl/capture_pkg.sv ====
package capture_pkg;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        COUNTDOWN = 2'd1,
        SHOOT     = 2'd2,
        DONE      = 2'd3
    } session_state_e;

    typedef enum logic [1:0] {
        TONE_OFF  = 2'd0,
        TONE_LOW  = 2'd1,
        TONE_HIGH = 2'd2
    } tone_e;

    typedef struct packed {
        logic [2:0] shot_idx;     // Shot number from 0
        logic [7:0] frame_stamp;  // v_sync edges since session start
        tone_e      tone;
    } shot_rec_t;

    // Shown on shot_num outside a session
    localparam logic [2:0] IDLE_NUM = 3'd7;

endpackage

// ==== rtl/btn_debounce.sv ====
`timescale 1ns/1ps

module btn_debounce #(
    parameter int DEBOUNCE_DIV = 100_000
) (
    input  logic clk,
    input  logic reset,
    input  logic btn_in,
    output logic press
);

    localparam int DW = $clog2(DEBOUNCE_DIV + 1);

    logic [DW-1:0] div_cnt;
    logic          sample_en;
    logic [3:0]    history;
    logic          all_high;
    logic          all_high_d;

    // Sample enable, one cycle every DEBOUNCE_DIV clocks
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            div_cnt   <= '0;
            sample_en <= 1'b0;
        end else if (div_cnt == DW'(DEBOUNCE_DIV - 1)) begin
            div_cnt   <= '0;
            sample_en <= 1'b1;
        end else begin
            div_cnt   <= div_cnt + 1'b1;
            sample_en <= 1'b0;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            history    <= '0;
            all_high_d <= 1'b0;
        end else begin
            if (sample_en) begin
                history <= {btn_in, history[3:1]};  // Newest sample at the top
            end
            all_high_d <= all_high;
        end
    end

    assign all_high = &history;
    assign press    = all_high & ~all_high_d;  // Rising edge only

endmodule

// ==== rtl/capture_ctrl.sv ====
`timescale 1ns/1ps

module capture_ctrl #(
    parameter int NUM_SHOTS   = 6,
    parameter int SHOT_CYCLES = 300_000_000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start_press,
    input  logic                   abort_press,
    input  logic                   v_sync,
    output logic                   push,
    output capture_pkg::shot_rec_t push_rec,
    output logic                   active,
    output logic                   finish,
    output logic [2:0]             shot_num
);

    import capture_pkg::*;

    localparam int         CW       = $clog2(SHOT_CYCLES + 1);
    localparam logic [2:0] LAST_IDX = 3'(NUM_SHOTS - 1);

    session_state_e state;
    logic [CW-1:0]  cnt;
    logic [2:0]     idx;
    logic [7:0]     stamp;
    logic           v_sync_d;
    logic           shoot_now;
    tone_e          tone;

    assign active    = (state != IDLE);
    assign finish    = (state == DONE);
    assign shot_num  = active ? idx : IDLE_NUM;
    assign tone      = (idx == LAST_IDX) ? TONE_HIGH : TONE_LOW;
    assign shoot_now = (state == SHOOT) && v_sync && !abort_press;

    // Session FSM, abort wins over everything
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
            idx   <= '0;
        end else if (abort_press) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_press) begin
                        state <= COUNTDOWN;
                        cnt   <= '0;
                        idx   <= '0;
                    end
                end
                COUNTDOWN: begin
                    if (cnt == CW'(SHOT_CYCLES - 1)) begin
                        state <= SHOOT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SHOOT: begin
                    if (v_sync) begin  // Align to frame
                        idx   <= idx + 1'b1;
                        cnt   <= '0;
                        state <= (idx == LAST_IDX) ? DONE : COUNTDOWN;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Frame stamp counts v_sync rising edges during a session
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            v_sync_d <= 1'b0;
            stamp    <= '0;
        end else begin
            v_sync_d <= v_sync;
            if ((state == IDLE) && start_press) begin
                stamp <= '0;
            end else if (active && v_sync && !v_sync_d) begin
                stamp <= stamp + 1'b1;  // Wraps at 256
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= shoot_now;
        end
    end

    always_ff @(posedge clk) begin
        if (shoot_now) begin
            push_rec.shot_idx    <= idx;
            push_rec.frame_stamp <= stamp;
            push_rec.tone        <= tone;
        end
    end

endmodule

// ==== rtl/shot_fifo.sv ====
`timescale 1ns/1ps

module shot_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  capture_pkg::shot_rec_t push_rec,
    input  logic                   pop,
    output capture_pkg::shot_rec_t pop_rec,
    output logic                   empty,
    output logic                   dropped
);

    import capture_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int NW = $clog2(FIFO_DEPTH + 1);

    shot_rec_t     mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [NW-1:0] count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == NW'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            if (push && full) begin
                dropped <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
        if (do_pop) begin
            pop_rec <= mem[rd_ptr];
        end
    end

endmodule

// ==== rtl/shutter_beeper.sv ====
`timescale 1ns/1ps

module shutter_beeper #(
    parameter int BEEP_CYCLES = 25_000_000,
    parameter int HALF_LOW    = 95_556,
    parameter int HALF_HIGH   = 47_778
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   empty,
    input  capture_pkg::shot_rec_t pop_rec,
    output logic                   pop,
    output capture_pkg::shot_rec_t shot_out,
    output logic                   shot_out_valid,
    output logic                   buzz
);

    import capture_pkg::*;

    typedef enum logic [1:0] {
        B_IDLE,
        B_FETCH,
        B_BEEP
    } beep_state_e;

    localparam int HALF_MAX = (HALF_LOW > HALF_HIGH) ? HALF_LOW : HALF_HIGH;
    localparam int BW       = $clog2(BEEP_CYCLES + 1);
    localparam int HW       = $clog2(HALF_MAX + 1);

    beep_state_e   state;
    logic [BW-1:0] beep_cnt;
    logic [HW-1:0] half_cnt;
    logic [HW-1:0] half_last;
    logic          tone_on;

    assign pop     = (state == B_IDLE) && !empty;
    assign tone_on = (shot_out.tone != TONE_OFF);

    always_comb begin
        case (shot_out.tone)
            TONE_HIGH: half_last = HW'(HALF_HIGH - 1);
            default:   half_last = HW'(HALF_LOW - 1);
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state          <= B_IDLE;
            beep_cnt       <= '0;
            half_cnt       <= '0;
            buzz           <= 1'b0;
            shot_out_valid <= 1'b0;
        end else begin
            shot_out_valid <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (!empty) begin
                        state <= B_FETCH;  // pop strobed this cycle
                    end
                end
                B_FETCH: begin
                    state          <= B_BEEP;
                    shot_out_valid <= 1'b1;
                    beep_cnt       <= '0;
                    half_cnt       <= '0;
                    buzz           <= (pop_rec.tone != TONE_OFF);
                end
                B_BEEP: begin
                    if (beep_cnt == BW'(BEEP_CYCLES - 1)) begin
                        state <= B_IDLE;
                        buzz  <= 1'b0;
                    end else begin
                        beep_cnt <= beep_cnt + 1'b1;
                        if (half_cnt == half_last) begin
                            half_cnt <= '0;
                            buzz     <= tone_on ? ~buzz : 1'b0;
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= B_IDLE;
                    buzz  <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == B_FETCH) begin
            shot_out <= pop_rec;  // Head record arrived last edge
        end
    end

endmodule

// ==== rtl/capture_top.sv ====
`timescale 1ns/1ps

module capture_top #(
    parameter int DEBOUNCE_DIV = 100_000,
    parameter int NUM_SHOTS    = 6,
    parameter int SHOT_CYCLES  = 300_000_000,  // 3 s at 100 MHz
    parameter int FIFO_DEPTH   = 8,
    parameter int BEEP_CYCLES  = 25_000_000,
    parameter int HALF_LOW     = 95_556,       // Around C5
    parameter int HALF_HIGH    = 47_778        // Around C6
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   btn,
    input  logic                   btn_reset,
    input  logic                   v_sync,
    output logic                   active,
    output logic [2:0]             shot_num,
    output logic                   finish,
    output capture_pkg::shot_rec_t shot_out,
    output logic                   shot_out_valid,
    output logic                   buzz,
    output logic                   dropped
);

    import capture_pkg::*;

    logic      start_press;
    logic      abort_press;
    logic      push;
    shot_rec_t push_rec;
    logic      pop;
    shot_rec_t pop_rec;
    logic      empty;

    btn_debounce #(.DEBOUNCE_DIV(DEBOUNCE_DIV)) u_start_db (
        .clk   (clk),
        .reset (reset),
        .btn_in(btn),
        .press (start_press)
    );

    btn_debounce #(.DEBOUNCE_DIV(DEBOUNCE_DIV)) u_abort_db (
        .clk   (clk),
        .reset (reset),
        .btn_in(btn_reset),
        .press (abort_press)
    );

    capture_ctrl #(
        .NUM_SHOTS  (NUM_SHOTS),
        .SHOT_CYCLES(SHOT_CYCLES)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start_press(start_press),
        .abort_press(abort_press),
        .v_sync     (v_sync),
        .push       (push),
        .push_rec   (push_rec),
        .active     (active),
        .finish     (finish),
        .shot_num   (shot_num)
    );

    shot_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk     (clk),
        .reset   (reset),
        .push    (push),
        .push_rec(push_rec),
        .pop     (pop),
        .pop_rec (pop_rec),
        .empty   (empty),
        .dropped (dropped)
    );

    shutter_beeper #(
        .BEEP_CYCLES(BEEP_CYCLES),
        .HALF_LOW   (HALF_LOW),
        .HALF_HIGH  (HALF_HIGH)
    ) u_beeper (
        .clk           (clk),
        .reset         (reset),
        .empty         (empty),
        .pop_rec       (pop_rec),
        .pop           (pop),
        .shot_out      (shot_out),
        .shot_out_valid(shot_out_valid),
        .buzz          (buzz)
    );

endmodule

// ==== verif/capture_asserts.sv ====
`timescale 1ns/1ps

module capture_asserts #(
    parameter int BEEP_CYCLES = 40
) (
    input logic clk,
    input logic reset,
    input logic active,
    input logic finish,
    input logic shot_out_valid,
    input logic pop,
    input logic buzz
);

    int   beep_left;  // Cycles left in the current beep
    logic finish_bad;
    logic valid_bad;
    logic pop_bad;
    logic buzz_bad;
    logic any_fail;

    initial begin
        finish_bad = 1'b0;
        valid_bad  = 1'b0;
        pop_bad    = 1'b0;
        buzz_bad   = 1'b0;
    end

    assign any_fail = finish_bad | valid_bad | pop_bad | buzz_bad;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            beep_left <= 0;
        end else if (shot_out_valid) begin
            beep_left <= BEEP_CYCLES;
        end else if (beep_left != 0) begin
            beep_left <= beep_left - 1;
        end
    end

    finish_one_cycle: assert property (@(posedge clk) disable iff (reset) finish |=> !finish)
        else begin
            $error("finish held high for more than one cycle");
            finish_bad = 1'b1;
        end

    valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
                                      shot_out_valid |=> !shot_out_valid)
        else begin
            $error("shot_out_valid held high for more than one cycle");
            valid_bad = 1'b1;
        end

    pop_one_cycle: assert property (@(posedge clk) disable iff (reset) pop |=> !pop)
        else begin
            $error("pop held high for more than one cycle");
            pop_bad = 1'b1;
        end

    buzz_quiet: assert property (@(posedge clk) disable iff (reset)
                                 (!active && !shot_out_valid && beep_left == 0) |-> !buzz)
        else begin
            $error("buzz high with no session and no beep");
            buzz_bad = 1'b1;
        end

endmodule

bind capture_top capture_asserts #(.BEEP_CYCLES(BEEP_CYCLES)) u_asserts (
    .clk           (clk),
    .reset         (reset),
    .active        (active),
    .finish        (finish),
    .shot_out_valid(shot_out_valid),
    .pop           (pop),
    .buzz          (buzz)
);

// ==== verif/tb_capture.sv ====
`timescale 1ns/1ps

module tb_capture;

    import capture_pkg::*;

    localparam int DEBOUNCE_DIV = 4;
    localparam int NUM_SHOTS    = 4;
    localparam int SHOT_CYCLES  = 50;
    localparam int FIFO_DEPTH   = 4;
    localparam int BEEP_CYCLES  = 40;
    localparam int HALF_LOW     = 5;
    localparam int HALF_HIGH    = 2;
    localparam int WAIT_LIMIT   = 2000;  // Cycles before a wait gives up

    logic       clk;
    logic       reset;
    logic       btn;
    logic       btn_reset;
    logic       v_sync;
    logic       active;
    logic [2:0] shot_num;
    logic       finish;
    shot_rec_t  shot_out;
    logic       shot_out_valid;
    logic       buzz;
    logic       dropped;

    integer     seed;
    shot_rec_t  exp_q[$];       // Shots taken, not yet published
    int         frames;         // Mirror of the frame stamp
    int         frames_old;
    int         shots_taken;
    logic       vs_seen;
    logic       act_seen;
    logic [2:0] num_seen;
    int         rec_count;
    int         finish_count;
    logic       finish_seen;
    logic       in_beep;
    int         beep_j;
    int         beep_half;

    capture_top #(
        .DEBOUNCE_DIV(DEBOUNCE_DIV),
        .NUM_SHOTS   (NUM_SHOTS),
        .SHOT_CYCLES (SHOT_CYCLES),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .BEEP_CYCLES (BEEP_CYCLES),
        .HALF_LOW    (HALF_LOW),
        .HALF_HIGH   (HALF_HIGH)
    ) u_capture_top (
        .clk           (clk),
        .reset         (reset),
        .btn           (btn),
        .btn_reset     (btn_reset),
        .v_sync        (v_sync),
        .active        (active),
        .shot_num      (shot_num),
        .finish        (finish),
        .shot_out      (shot_out),
        .shot_out_valid(shot_out_valid),
        .buzz          (buzz),
        .dropped       (dropped)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_with_failure($sformatf("Fail at %0t: %s is %0d, expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    // Expected record from the shot number and the counted frames
    function automatic shot_rec_t expected_record(input int idx, input int stamp);
        shot_rec_t rec;
        rec.shot_idx    = idx[2:0];
        rec.frame_stamp = stamp[7:0];
        rec.tone        = (idx == NUM_SHOTS - 1) ? TONE_HIGH : TONE_LOW;
        return rec;
    endfunction

    task automatic wait_active(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (active !== level) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure({"Timeout waiting for ", what});
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_records(input int count, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (rec_count < count) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure({"Timeout waiting for ", what});
            end
            n++;
            @(posedge clk);
        end
    endtask

    task automatic wait_beep_done;
        int n;
        n = 0;
        @(posedge clk);
        while (in_beep) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure("Timeout waiting for the last beep to end");
            end
            n++;
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            v_sync <= (($random(seed) & 32'h3) == 0);  // High about one cycle in four
        end
    end

    // Frame count and shot detection, seen on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            frames      = 0;
            frames_old  = 0;
            shots_taken = 0;
            vs_seen     = 1'b0;
            act_seen    = 1'b0;
            num_seen    = IDLE_NUM;
        end else begin
            if (act_seen && active && (shot_num != num_seen)) begin  // Shot on last edge
                check_value("v_sync at shot", int'(vs_seen), 1);
                exp_q.push_back(expected_record(shots_taken, frames_old));
                shots_taken++;
                check_value("shot_num", int'(shot_num), shots_taken);
            end
            frames_old = frames;
            if (!active) begin
                frames      = 0;
                shots_taken = 0;
            end else if (v_sync && !vs_seen) begin
                frames = (frames + 1) % 256;
            end
            vs_seen  = v_sync;
            act_seen = active;
            num_seen = shot_num;
        end
    end

    // Compare published records, buzz and the session strobes
    always @(negedge clk) begin
        shot_rec_t exp_rec;
        if (!reset) begin
            if (u_capture_top.u_asserts.any_fail) begin
                stop_with_failure("A concurrent assertion on capture_top failed");
            end
            check_value("dropped", int'(dropped), 0);
            if (!active) begin
                check_value("shot_num", int'(shot_num), int'(IDLE_NUM));
            end
            if (shot_out_valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("A record was published although no shot was taken");
                end else begin
                    exp_rec = exp_q.pop_front();
                    check_value("shot_out.shot_idx", int'(shot_out.shot_idx),
                                int'(exp_rec.shot_idx));
                    check_value("shot_out.frame_stamp", int'(shot_out.frame_stamp),
                                int'(exp_rec.frame_stamp));
                    check_value("shot_out.tone", int'(shot_out.tone), int'(exp_rec.tone));
                    rec_count++;
                    in_beep   = 1'b1;
                    beep_j    = 0;
                    beep_half = (exp_rec.tone == TONE_HIGH) ? HALF_HIGH : HALF_LOW;
                end
            end
            if (in_beep) begin
                check_value("buzz", int'(buzz), ((beep_j / beep_half) % 2 == 0) ? 1 : 0);
                beep_j++;
                if (beep_j == BEEP_CYCLES) begin
                    in_beep = 1'b0;
                end
            end else begin
                check_value("buzz", int'(buzz), 0);
            end
            if (finish_seen) begin
                check_value("active after finish", int'(active), 0);
            end
            finish_seen = finish;
            if (finish) begin
                check_value("active with finish", int'(active), 1);
                finish_count++;
            end
        end
    end

    initial begin
        int recs_before;
        int fins_before;
        seed         = 17349;
        rec_count    = 0;
        finish_count = 0;
        finish_seen  = 1'b0;
        in_beep      = 1'b0;
        beep_j       = 0;
        beep_half    = HALF_LOW;
        reset        = 1'b1;
        btn          = 1'b0;
        btn_reset    = 1'b0;
        v_sync       = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("active", int'(active), 0);
        check_value("finish", int'(finish), 0);
        check_value("shot_out_valid", int'(shot_out_valid), 0);
        check_value("buzz", int'(buzz), 0);
        check_value("dropped", int'(dropped), 0);
        check_value("shot_num", int'(shot_num), int'(IDLE_NUM));

        // Full session, second start press lands after the first record
        @(posedge clk);
        btn <= 1'b1;
        wait_active(1'b1, "active after the start press");
        @(posedge clk);
        btn <= 1'b0;
        wait_records(1, "the first record of the first session");
        @(posedge clk);
        btn <= 1'b1;
        repeat (24) @(posedge clk);
        btn <= 1'b0;
        wait_records(NUM_SHOTS, "all records of the first session");
        wait_active(1'b0, "the end of the first session");
        wait_beep_done();
        check_value("records in session", rec_count, NUM_SHOTS);
        check_value("finish pulses", finish_count, 1);
        check_value("pending shots", exp_q.size(), 0);

        // Abort right after the first record of a new session
        @(posedge clk);
        btn <= 1'b1;
        wait_active(1'b1, "active after the second start press");
        @(posedge clk);
        btn <= 1'b0;
        wait_records(NUM_SHOTS + 1, "the first record of the second session");
        @(posedge clk);
        btn_reset <= 1'b1;
        wait_active(1'b0, "active to drop after the abort press");
        @(posedge clk);
        btn_reset   <= 1'b0;
        recs_before = rec_count;
        fins_before = finish_count;
        repeat (2 * (SHOT_CYCLES + BEEP_CYCLES)) @(posedge clk);
        check_value("records after abort", rec_count, recs_before);
        check_value("finish pulses after abort", finish_count, fins_before);
        check_value("pending shots after abort", exp_q.size(), 0);
        check_value("active after abort", int'(active), 0);

        @(negedge clk);
        if (!u_capture_top.u_asserts.any_fail) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/capture_pkg.sv
rtl/btn_debounce.sv
rtl/capture_ctrl.sv
rtl/shot_fifo.sv
rtl/shutter_beeper.sv
rtl/capture_top.sv
verif/capture_asserts.sv
verif/tb_capture.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_capture
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
